// File: Bender.yml
package:
  name: gpu_front

sources:
  - src/gpu_cfg_pkg.sv
  - src/gpu_isa_pkg.sv
  - src/warp_fetcher.sv
  - src/instruction_memory.sv
  - src/instruction_decoder.sv
  - src/gpu_front.sv
  - target: test
    files:
      - tb/tb_gpu_front.sv

// File: gpu_front.f
src/gpu_cfg_pkg.sv
src/gpu_isa_pkg.sv
src/warp_fetcher.sv
src/instruction_memory.sv
src/instruction_decoder.sv
src/gpu_front.sv
tb/tb_gpu_front.sv

// File: src/gpu_cfg_pkg.sv
// Sizing constants of one compute unit front end
// PCs count instruction words, not bytes
// The program store covers only the low MEM_DEPTH words of the PC range
`default_nettype none

package gpu_cfg_pkg;

    // Warps and threads
    localparam int unsigned NUM_WARPS  = 8;
    localparam int unsigned WID_WIDTH  = 3;
    // Threads per warp, also the active mask width
    localparam int unsigned WARP_WIDTH = 32;

    // Program counter in words
    localparam int unsigned PC_WIDTH = 10;

    // Program store, PCs from MEM_DEPTH upward are out of range
    localparam int unsigned MEM_DEPTH      = 512;
    localparam int unsigned MEM_ADDR_WIDTH = 9;

    // Encoded instruction word
    localparam int unsigned INST_WIDTH = 32;

endpackage : gpu_cfg_pkg

`default_nettype wire

// File: src/gpu_front.sv
// Front end of one compute unit: fetch, lookup, decode
// Program must be loaded before the warps that run it are launched
// warps_active_o shows which warps have not yet retired
`default_nettype none

module gpu_front (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    // Warp launch
    input  logic                                 launch_i,
    input  logic [gpu_cfg_pkg::WID_WIDTH-1:0]    launch_warp_id_i,
    input  logic [gpu_cfg_pkg::PC_WIDTH-1:0]     launch_pc_i,
    input  logic [gpu_cfg_pkg::WARP_WIDTH-1:0]   launch_act_mask_i,
    // Program load
    input  logic                                 mem_write_i,
    input  logic [gpu_cfg_pkg::PC_WIDTH-1:0]     mem_addr_i,
    input  logic [gpu_cfg_pkg::INST_WIDTH-1:0]   mem_inst_i,
    // Decoded instruction out
    input  logic                                 out_ready_i,
    output logic                                 out_valid_o,
    output logic [gpu_cfg_pkg::WID_WIDTH-1:0]    out_warp_id_o,
    output logic [gpu_cfg_pkg::PC_WIDTH-1:0]     out_pc_o,
    output logic [gpu_cfg_pkg::WARP_WIDTH-1:0]   out_act_mask_o,
    output logic [gpu_isa_pkg::OPC_WIDTH-1:0]    out_opcode_o,
    output logic [gpu_isa_pkg::REG_WIDTH-1:0]    out_rd_o,
    output logic [gpu_isa_pkg::REG_WIDTH-1:0]    out_rs1_o,
    output logic [gpu_isa_pkg::REG_WIDTH-1:0]    out_rs2_o,
    output logic [gpu_isa_pkg::FUNC_WIDTH-1:0]   out_func_o,
    output logic                                 out_illegal_o,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0]    warps_active_o
);
    import gpu_cfg_pkg::*;

    // Fetch stage
    logic                  fe_valid;
    logic [PC_WIDTH-1:0]   fe_pc;
    logic [WARP_WIDTH-1:0] fe_act_mask;
    logic [WID_WIDTH-1:0]  fe_warp_id;
    logic                  ic_ready;

    // Memory stage
    logic                  ic_valid;
    logic [PC_WIDTH-1:0]   ic_pc;
    logic [WARP_WIDTH-1:0] ic_act_mask;
    logic [WID_WIDTH-1:0]  ic_warp_id;
    logic [INST_WIDTH-1:0] ic_inst;
    logic                  dec_ready;

    // Resolve loop
    logic                  res_valid;
    logic [WID_WIDTH-1:0]  res_warp_id;
    logic [PC_WIDTH-1:0]   res_next_pc;
    logic                  res_exit;

    warp_fetcher i_fetcher (
        .clk_i, .arst_n_i,
        .launch_i, .launch_warp_id_i, .launch_pc_i, .launch_act_mask_i,
        .res_valid_i   (res_valid),
        .res_warp_id_i (res_warp_id),
        .res_next_pc_i (res_next_pc),
        .res_exit_i    (res_exit),
        .fe_ready_i    (ic_ready),
        .fe_valid_o    (fe_valid),
        .fe_pc_o       (fe_pc),
        .fe_act_mask_o (fe_act_mask),
        .fe_warp_id_o  (fe_warp_id),
        .warps_active_o
    );

    instruction_memory i_memory (
        .clk_i,
        .mem_write_i, .mem_addr_i, .mem_inst_i,
        .ic_ready_o    (ic_ready),
        .fe_valid_i    (fe_valid),
        .fe_pc_i       (fe_pc),
        .fe_act_mask_i (fe_act_mask),
        .fe_warp_id_i  (fe_warp_id),
        .dec_ready_i   (dec_ready),
        .ic_valid_o    (ic_valid),
        .ic_pc_o       (ic_pc),
        .ic_act_mask_o (ic_act_mask),
        .ic_warp_id_o  (ic_warp_id),
        .ic_inst_o     (ic_inst)
    );

    instruction_decoder i_decoder (
        .clk_i, .arst_n_i,
        .ic_valid_i    (ic_valid),
        .ic_pc_i       (ic_pc),
        .ic_act_mask_i (ic_act_mask),
        .ic_warp_id_i  (ic_warp_id),
        .ic_inst_i     (ic_inst),
        .dec_ready_o   (dec_ready),
        .out_ready_i, .out_valid_o, .out_warp_id_o, .out_pc_o, .out_act_mask_o,
        .out_opcode_o, .out_rd_o, .out_rs1_o, .out_rs2_o, .out_func_o,
        .out_illegal_o,
        .res_valid_o   (res_valid),
        .res_warp_id_o (res_warp_id),
        .res_next_pc_o (res_next_pc),
        .res_exit_o    (res_exit)
    );

endmodule : gpu_front

`default_nettype wire

// File: src/gpu_isa_pkg.sv
// Instruction set of the front end
// Every word carries the opcode in its top bits; the rest depends on format
// Opcodes above OPC_EXIT are illegal
`default_nettype none

package gpu_isa_pkg;

    // Field widths
    localparam int unsigned OPC_WIDTH    = 6;
    localparam int unsigned REG_WIDTH    = 5;
    localparam int unsigned FUNC_WIDTH   = 11;
    localparam int unsigned TARGET_WIDTH = 26;

    // Legal opcodes
    localparam logic [OPC_WIDTH-1:0] OPC_NOP  = 6'd0;
    localparam logic [OPC_WIDTH-1:0] OPC_ALU  = 6'd1;
    localparam logic [OPC_WIDTH-1:0] OPC_JUMP = 6'd2;
    localparam logic [OPC_WIDTH-1:0] OPC_EXIT = 6'd3;

    // ########################################################################
    // Instruction formats
    // ########################################################################

    // Register format, 6 + 5 + 5 + 5 + 11 bits
    typedef struct packed {
        logic [OPC_WIDTH-1:0]  opcode;
        logic [REG_WIDTH-1:0]  rd;
        logic [REG_WIDTH-1:0]  rs1;
        logic [REG_WIDTH-1:0]  rs2;
        logic [FUNC_WIDTH-1:0] func;
    } inst_alu_t;

    // Jump format, 6 + 26 bits
    // Only the low PC bits of the target matter
    typedef struct packed {
        logic [OPC_WIDTH-1:0]    opcode;
        logic [TARGET_WIDTH-1:0] target;
    } inst_jump_t;

    // Same word seen in both formats
    typedef union packed {
        inst_alu_t  alu;
        inst_jump_t jump;
    } inst_u;

endpackage : gpu_isa_pkg

`default_nettype wire

// File: src/instruction_decoder.sv
// One-entry registered decode stage with valid/ready on both sides
// ALU fields are given for every opcode, meaningful only for ALU
// Resolve outputs fire on the output handshake, same cycle
// Next PC wraps at the PC width; jump targets keep their low PC bits only
`default_nettype none

module instruction_decoder (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    // From memory
    input  logic                                 ic_valid_i,
    input  logic [gpu_cfg_pkg::PC_WIDTH-1:0]     ic_pc_i,
    input  logic [gpu_cfg_pkg::WARP_WIDTH-1:0]   ic_act_mask_i,
    input  logic [gpu_cfg_pkg::WID_WIDTH-1:0]    ic_warp_id_i,
    input  logic [gpu_cfg_pkg::INST_WIDTH-1:0]   ic_inst_i,
    output logic                                 dec_ready_o,
    // Decoded instruction out
    input  logic                                 out_ready_i,
    output logic                                 out_valid_o,
    output logic [gpu_cfg_pkg::WID_WIDTH-1:0]    out_warp_id_o,
    output logic [gpu_cfg_pkg::PC_WIDTH-1:0]     out_pc_o,
    output logic [gpu_cfg_pkg::WARP_WIDTH-1:0]   out_act_mask_o,
    output logic [gpu_isa_pkg::OPC_WIDTH-1:0]    out_opcode_o,
    output logic [gpu_isa_pkg::REG_WIDTH-1:0]    out_rd_o,
    output logic [gpu_isa_pkg::REG_WIDTH-1:0]    out_rs1_o,
    output logic [gpu_isa_pkg::REG_WIDTH-1:0]    out_rs2_o,
    output logic [gpu_isa_pkg::FUNC_WIDTH-1:0]   out_func_o,
    output logic                                 out_illegal_o,
    // Resolve back to fetcher
    output logic                                 res_valid_o,
    output logic [gpu_cfg_pkg::WID_WIDTH-1:0]    res_warp_id_o,
    output logic [gpu_cfg_pkg::PC_WIDTH-1:0]     res_next_pc_o,
    output logic                                 res_exit_o
);
    import gpu_cfg_pkg::*;
    import gpu_isa_pkg::*;

    // ########################################################################
    // Field decode
    // ########################################################################

    inst_u                 inst;
    logic [OPC_WIDTH-1:0]  opcode;
    logic                  illegal;
    logic [PC_WIDTH-1:0]   next_pc;
    logic                  take_in;

    // Registered resolve info
    logic [PC_WIDTH-1:0] next_pc_q;
    logic                exit_q;

    assign inst   = ic_inst_i;
    assign opcode = inst.alu.opcode;

    // Anything outside the four known opcodes
    assign illegal = !(opcode inside {OPC_NOP, OPC_ALU, OPC_JUMP, OPC_EXIT});

    // Jump target or sequential, illegal falls through to PC + 1
    assign next_pc = (opcode == OPC_JUMP) ? inst.jump.target[PC_WIDTH-1:0]
                                          : ic_pc_i + PC_WIDTH'(1);

    // ########################################################################
    // Register stage
    // ########################################################################

    // Empty, or current entry leaves this cycle
    assign dec_ready_o = !out_valid_o || out_ready_i;
    assign take_in     = ic_valid_i && dec_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (dec_ready_o) begin
            out_valid_o <= ic_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_in) begin
            out_warp_id_o  <= ic_warp_id_i;
            out_pc_o       <= ic_pc_i;
            out_act_mask_o <= ic_act_mask_i;
            out_opcode_o   <= opcode;
            out_rd_o       <= inst.alu.rd;
            out_rs1_o      <= inst.alu.rs1;
            out_rs2_o      <= inst.alu.rs2;
            out_func_o     <= inst.alu.func;
            out_illegal_o  <= illegal;
            next_pc_q      <= next_pc;
            exit_q         <= (opcode == OPC_EXIT);
        end
    end

    // Resolve rides on the output handshake
    assign res_valid_o   = out_valid_o && out_ready_i;
    assign res_warp_id_o = out_warp_id_o;
    assign res_next_pc_o = next_pc_q;
    assign res_exit_o    = exit_q;

    // Stalled output keeps valid and every field
    a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable({out_warp_id_o,
        out_pc_o, out_act_mask_o, out_opcode_o, out_rd_o, out_rs1_o, out_rs2_o,
        out_func_o, out_illegal_o, next_pc_q, exit_q}))
        else $error("decoder output changed while stalled");

endmodule : instruction_decoder

`default_nettype wire

// File: src/instruction_memory.sv
// Lookup program store in place of an instruction cache, no misses
// Writes above MEM_DEPTH are dropped; reads there return zero (a NOP)
// Handshake and warp context pass through with zero latency
`default_nettype none

module instruction_memory (
    input  logic                                 clk_i,
    // Program load
    input  logic                                 mem_write_i,
    input  logic [gpu_cfg_pkg::PC_WIDTH-1:0]     mem_addr_i,
    input  logic [gpu_cfg_pkg::INST_WIDTH-1:0]   mem_inst_i,
    // From fetcher
    output logic                                 ic_ready_o,
    input  logic                                 fe_valid_i,
    input  logic [gpu_cfg_pkg::PC_WIDTH-1:0]     fe_pc_i,
    input  logic [gpu_cfg_pkg::WARP_WIDTH-1:0]   fe_act_mask_i,
    input  logic [gpu_cfg_pkg::WID_WIDTH-1:0]    fe_warp_id_i,
    // To decoder
    input  logic                                 dec_ready_i,
    output logic                                 ic_valid_o,
    output logic [gpu_cfg_pkg::PC_WIDTH-1:0]     ic_pc_o,
    output logic [gpu_cfg_pkg::WARP_WIDTH-1:0]   ic_act_mask_o,
    output logic [gpu_cfg_pkg::WID_WIDTH-1:0]    ic_warp_id_o,
    output logic [gpu_cfg_pkg::INST_WIDTH-1:0]   ic_inst_o
);
    import gpu_cfg_pkg::*;

    // Program words
    logic [INST_WIDTH-1:0] mem_q [MEM_DEPTH];

    // Write port, out of range addresses ignored
    always_ff @(posedge clk_i) begin
        if (mem_write_i && mem_addr_i < MEM_DEPTH) begin
            mem_q[mem_addr_i[MEM_ADDR_WIDTH-1:0]] <= mem_inst_i;
        end
    end

    // Combinational read
    assign ic_inst_o = (fe_pc_i < MEM_DEPTH) ? mem_q[fe_pc_i[MEM_ADDR_WIDTH-1:0]] : '0;

    // Handshake follows the decoder
    assign ic_ready_o = dec_ready_i;
    assign ic_valid_o = fe_valid_i;

    // Warp context rides along with the word
    assign ic_pc_o       = fe_pc_i;
    assign ic_act_mask_o = fe_act_mask_i;
    assign ic_warp_id_o  = fe_warp_id_i;

    // Loader should stay inside the store
    a_write_in_range: assert property (@(posedge clk_i)
        mem_write_i |-> mem_addr_i < MEM_DEPTH)
        else $warning("program write to %0d dropped", mem_addr_i);

endmodule : instruction_memory

`default_nettype wire

// File: src/warp_fetcher.sv
// Warp table and round-robin fetch stage
// A warp has at most one instruction in flight: pending from grant to resolve
// Launching a warp that is still active is illegal
// The fetch register holds its content while fe_ready_i is low
`default_nettype none

module warp_fetcher (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    // Launch of a warp
    input  logic                                 launch_i,
    input  logic [gpu_cfg_pkg::WID_WIDTH-1:0]    launch_warp_id_i,
    input  logic [gpu_cfg_pkg::PC_WIDTH-1:0]     launch_pc_i,
    input  logic [gpu_cfg_pkg::WARP_WIDTH-1:0]   launch_act_mask_i,
    // Resolve from decode
    input  logic                                 res_valid_i,
    input  logic [gpu_cfg_pkg::WID_WIDTH-1:0]    res_warp_id_i,
    input  logic [gpu_cfg_pkg::PC_WIDTH-1:0]     res_next_pc_i,
    input  logic                                 res_exit_i,
    // Fetch handshake towards memory
    input  logic                                 fe_ready_i,
    output logic                                 fe_valid_o,
    output logic [gpu_cfg_pkg::PC_WIDTH-1:0]     fe_pc_o,
    output logic [gpu_cfg_pkg::WARP_WIDTH-1:0]   fe_act_mask_o,
    output logic [gpu_cfg_pkg::WID_WIDTH-1:0]    fe_warp_id_o,
    output logic [gpu_cfg_pkg::NUM_WARPS-1:0]    warps_active_o
);
    import gpu_cfg_pkg::*;

    // ########################################################################
    // Warp table
    // ########################################################################

    logic [PC_WIDTH-1:0]   pc_q   [NUM_WARPS];
    logic [WARP_WIDTH-1:0] mask_q [NUM_WARPS];
    logic [NUM_WARPS-1:0]  active_q;
    logic [NUM_WARPS-1:0]  pending_q;

    // Round-robin state, points at the last granted warp
    logic [WID_WIDTH-1:0] rr_ptr_q;

    logic [NUM_WARPS-1:0] eligible;
    logic                 sel_found;
    logic [WID_WIDTH-1:0] sel_wid;
    logic                 fe_load;
    logic                 grant;

    // Active and not waiting on its previous instruction
    assign eligible = active_q & ~pending_q;

    // ########################################################################
    // Selection
    // ########################################################################

    // Search starts one past the last grant and wraps around
    always_comb begin
        logic [WID_WIDTH-1:0] idx;
        sel_found = 1'b0;
        sel_wid   = rr_ptr_q;
        for (int i = 1; i <= NUM_WARPS; i++) begin
            idx = rr_ptr_q + WID_WIDTH'(i);
            if (!sel_found && eligible[idx]) begin
                sel_found = 1'b1;
                sel_wid   = idx;
            end
        end
    end

    // Fetch register empty or draining this cycle
    assign fe_load = !fe_valid_o || fe_ready_i;
    assign grant   = fe_load && sel_found;

    // Control state
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q   <= '0;
            pending_q  <= '0;
            rr_ptr_q   <= '1;
            fe_valid_o <= 1'b0;
        end else begin
            if (fe_load) begin
                fe_valid_o <= sel_found;
            end
            if (grant) begin
                pending_q[sel_wid] <= 1'b1;
                rr_ptr_q           <= sel_wid;
            end
            // Resolved warp may fetch again, or retires on EXIT
            if (res_valid_i) begin
                pending_q[res_warp_id_i] <= 1'b0;
                if (res_exit_i) begin
                    active_q[res_warp_id_i] <= 1'b0;
                end
            end
            if (launch_i) begin
                active_q[launch_warp_id_i] <= 1'b1;
            end
        end
    end

    // Payload, PC and mask per warp plus fetch register
    always_ff @(posedge clk_i) begin
        if (res_valid_i && !res_exit_i) begin
            pc_q[res_warp_id_i] <= res_next_pc_i;
        end
        if (launch_i) begin
            pc_q[launch_warp_id_i]   <= launch_pc_i;
            mask_q[launch_warp_id_i] <= launch_act_mask_i;
        end
        if (grant) begin
            fe_pc_o       <= pc_q[sel_wid];
            fe_act_mask_o <= mask_q[sel_wid];
            fe_warp_id_o  <= sel_wid;
        end
    end

    assign warps_active_o = active_q;

    // ########################################################################
    // Checks
    // ########################################################################

    // Outside must wait for EXIT before relaunching a warp
    a_launch_inactive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        launch_i |-> !active_q[launch_warp_id_i])
        else $error("launch of active warp %0d", launch_warp_id_i);

    // Decode may only resolve an instruction that was granted here
    a_resolve_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        res_valid_i |-> pending_q[res_warp_id_i])
        else $error("resolve of warp %0d without pending fetch", res_warp_id_i);

endmodule : warp_fetcher

`default_nettype wire

// File: tb/tb_gpu_front.sv
// Testbench for the compute unit front end
// Fills the whole program store first, so every in-range PC holds a known word
// Programs are bounded by EXIT; the walk of each launch gives the expected count
// PCs from MEM_DEPTH upward are mirrored as zero words (NOP)
`default_nettype none

module tb_gpu_front;
    timeunit 1ns;
    timeprecision 1ps;
    import gpu_cfg_pkg::*;
    import gpu_isa_pkg::*;

    localparam int CLK_PERIOD     = 20;
    // Upper bound on instructions over all tests for the watchdog
    localparam int EXP_INSTS      = 128;
    localparam int TIMEOUT_CYCLES = EXP_INSTS * NUM_WARPS * 6 + 1024;

    // Start PCs of the eight-warp workload
    localparam logic [PC_WIDTH-1:0] START_PC [NUM_WARPS] = '{
        10'h000, 10'h040, 10'h080, 10'h0c0, 10'h0c4, 10'h002, 10'h045, 10'h081
    };

    // Expected decode of one word
    typedef struct packed {
        logic [OPC_WIDTH-1:0]  opcode;
        logic [REG_WIDTH-1:0]  rd;
        logic [REG_WIDTH-1:0]  rs1;
        logic [REG_WIDTH-1:0]  rs2;
        logic [FUNC_WIDTH-1:0] func;
        logic                  illegal;
        logic [PC_WIDTH-1:0]   next_pc;
        logic                  is_exit;
    } ref_t;

    logic                    clk_i = 1'b0;
    logic                    arst_n_i;
    logic                    launch_i;
    logic [WID_WIDTH-1:0]    launch_warp_id_i;
    logic [PC_WIDTH-1:0]     launch_pc_i;
    logic [WARP_WIDTH-1:0]   launch_act_mask_i;
    logic                    mem_write_i;
    logic [PC_WIDTH-1:0]     mem_addr_i;
    logic [INST_WIDTH-1:0]   mem_inst_i;
    logic                    out_ready_i;
    logic                    out_valid_o;
    logic [WID_WIDTH-1:0]    out_warp_id_o;
    logic [PC_WIDTH-1:0]     out_pc_o;
    logic [WARP_WIDTH-1:0]   out_act_mask_o;
    logic [OPC_WIDTH-1:0]    out_opcode_o;
    logic [REG_WIDTH-1:0]    out_rd_o;
    logic [REG_WIDTH-1:0]    out_rs1_o;
    logic [REG_WIDTH-1:0]    out_rs2_o;
    logic [FUNC_WIDTH-1:0]   out_func_o;
    logic                    out_illegal_o;
    logic [NUM_WARPS-1:0]    warps_active_o;

    // Mirror of the program over the full PC range
    logic [INST_WIDTH-1:0] prog [2**PC_WIDTH];
    // Per-warp expectation
    logic [PC_WIDTH-1:0]   exp_pc   [NUM_WARPS];
    logic [WARP_WIDTH-1:0] exp_mask [NUM_WARPS];
    logic [NUM_WARPS-1:0]  exp_active;
    int                    launches [NUM_WARPS];
    int                    retires  [NUM_WARPS];
    // Active masks for the launches in order
    logic [WARP_WIDTH-1:0] mask_pool [2*NUM_WARPS];
    int                    mask_next  = 0;
    int                    seen_insts = 0;
    int                    exp_insts  = 0;
    logic                  rand_ready = 1'b0;
    logic                  exit_chk   = 1'b0;
    logic [WID_WIDTH-1:0]  exit_wid;
    logic                  counts_ok;
    integer                seed = 32'hc17c;

    gpu_front UUT (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ########################################################################
    // Reference model and helpers
    // ########################################################################

    // Field split and next PC straight from the ISA rules
    function automatic ref_t ref_decode(input logic [INST_WIDTH-1:0] word,
                                        input logic [PC_WIDTH-1:0]   pc);
        ref_t r;
        r.opcode  = word[31:26];
        r.rd      = word[25:21];
        r.rs1     = word[20:16];
        r.rs2     = word[15:11];
        r.func    = word[10:0];
        r.illegal = (r.opcode > OPC_EXIT);
        r.is_exit = (r.opcode == OPC_EXIT);
        // Jumps keep only the low PC bits of the target
        if (r.opcode == OPC_JUMP) begin
            r.next_pc = word[PC_WIDTH-1:0];
        end else begin
            r.next_pc = pc + 1'b1;
        end
        return r;
    endfunction

    // Number of instructions a warp issues from start to EXIT
    function automatic int path_len(input logic [PC_WIDTH-1:0] start);
        logic [PC_WIDTH-1:0] pc;
        ref_t                r;
        int                  n;
        pc = start;
        n  = 0;
        do begin
            r  = ref_decode(prog[pc], pc);
            pc = r.next_pc;
            n++;
        end while (!r.is_exit && n < 4096);
        return n;
    endfunction

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic write_word(input logic [PC_WIDTH-1:0] addr, input logic [INST_WIDTH-1:0] word);
        @(posedge clk_i);
        mem_write_i <= 1'b1;
        mem_addr_i  <= addr;
        mem_inst_i  <= word;
        prog[addr] = word;
    endtask

    // Launch that also books the expected path
    task automatic launch_warp(input logic [WID_WIDTH-1:0] wid, input logic [PC_WIDTH-1:0] pc);
        logic [WARP_WIDTH-1:0] mask;
        mask = mask_pool[mask_next];
        mask_next++;
        @(posedge clk_i);
        launch_i          <= 1'b1;
        launch_warp_id_i  <= wid;
        launch_pc_i       <= pc;
        launch_act_mask_i <= mask;
        exp_pc[wid]     = pc;
        exp_mask[wid]   = mask;
        exp_active[wid] = 1'b1;
        launches[wid]++;
        exp_insts += path_len(pc);
        @(posedge clk_i);
        launch_i <= 1'b0;
    endtask

    // Until every warp has retired and the output is drained
    task automatic wait_idle();
        do begin
            @(posedge clk_i);
        end while (warps_active_o != '0 || out_valid_o);
    endtask

    // ########################################################################
    // Stimulus
    // ########################################################################

    // Output ready about 3 in 4 cycles during the stall phase
    always @(posedge clk_i) begin
        if (rand_ready) begin
            out_ready_i <= (($random(seed) & 3) != 0);
        end else begin
            out_ready_i <= 1'b1;
        end
    end

    initial begin
        arst_n_i          <= 1'b0;
        launch_i          <= 1'b0;
        launch_warp_id_i  <= '0;
        launch_pc_i       <= '0;
        launch_act_mask_i <= '0;
        mem_write_i       <= 1'b0;
        mem_addr_i        <= '0;
        mem_inst_i        <= '0;
        out_ready_i       <= 1'b1;
        exp_active = '0;
        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // Reset state
        @(posedge clk_i);
        check_equal("out_valid_o", out_valid_o, 1'b0);
        check_equal("warps_active_o", warps_active_o, '0);

        // Fill with NOP words that fold the whole address into the low bits
        for (int a = 0; a < MEM_DEPTH; a++) begin
            write_word(PC_WIDTH'(a), {OPC_NOP, 16'(~a), 10'(a)});
        end
        for (int a = MEM_DEPTH; a < 2**PC_WIDTH; a++) begin
            prog[a] = '0;
        end

        // Straight line at 0x000
        write_word(10'h000, {OPC_ALU, 26'($random(seed))});
        write_word(10'h001, {OPC_NOP, 26'($random(seed))});
        write_word(10'h002, {OPC_ALU, 26'($random(seed))});
        write_word(10'h003, {OPC_ALU, 26'($random(seed))});
        write_word(10'h004, {OPC_EXIT, 26'($random(seed))});
        // Forward jump, then a backward jump left by a later jump out
        write_word(10'h040, {OPC_ALU, 26'($random(seed))});
        write_word(10'h041, {OPC_JUMP, 16'h0, 10'h045});
        write_word(10'h045, {OPC_ALU, 26'($random(seed))});
        write_word(10'h046, {OPC_JUMP, 16'h0, 10'h050});
        write_word(10'h047, {OPC_ALU, 26'($random(seed))});
        write_word(10'h048, {OPC_JUMP, 16'h0, 10'h052});
        write_word(10'h050, {OPC_ALU, 26'($random(seed))});
        write_word(10'h051, {OPC_JUMP, 16'h0, 10'h047});
        write_word(10'h052, {OPC_EXIT, 26'($random(seed))});
        // Illegal opcode, then a jump out of range that wraps into 0x000
        write_word(10'h080, {6'h2a, 26'($random(seed))});
        write_word(10'h081, {OPC_ALU, 26'($random(seed))});
        write_word(10'h082, {OPC_JUMP, 16'h1234, 10'h3fe});
        // Longer straight run
        for (int a = 'h0c0; a < 'h0cc; a++) begin
            write_word(PC_WIDTH'(a), {OPC_ALU, 26'($random(seed))});
        end
        write_word(10'h0cc, {OPC_EXIT, 26'($random(seed))});
        @(posedge clk_i);
        mem_write_i <= 1'b0;
        for (int i = 0; i < 2 * NUM_WARPS; i++) begin
            mask_pool[i] = $random(seed);
        end

        // Single warps one at a time
        launch_warp(3'd0, 10'h000);
        wait_idle();
        launch_warp(3'd1, 10'h040);
        wait_idle();
        launch_warp(3'd2, 10'h080);
        wait_idle();

        // All warps together under random back-pressure
        rand_ready <= 1'b1;
        for (int w = 0; w < NUM_WARPS; w++) begin
            launch_warp(WID_WIDTH'(w), START_PC[w]);
        end
        wait_idle();
        rand_ready <= 1'b0;

        // Relaunch of a retired warp
        launch_warp(3'd2, 10'h0c0);
        wait_idle();
        repeat (2) @(posedge clk_i);

        counts_ok = (seen_insts == exp_insts) && (warps_active_o == '0);
        for (int w = 0; w < NUM_WARPS; w++) begin
            counts_ok = counts_ok && (retires[w] == launches[w]);
        end
        if (counts_ok) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Instruction or retire counts wrong, %0d seen and %0d expected",
                     seen_insts, exp_insts);
            $display("Test failed");
            $fatal(1, "count check at end of run");
        end
    end

    // ########################################################################
    // Compare and watchdog
    // ########################################################################

    // Every output handshake against the reference walk of its warp
    always @(posedge clk_i) begin : compare_outputs
        ref_t                 r;
        logic [WID_WIDTH-1:0] wid;
        // Warp bit drops one edge after the EXIT handshake
        if (exit_chk) begin
            check_equal("warps_active_o bit of retired warp", warps_active_o[exit_wid], 1'b0);
            exit_chk = 1'b0;
        end
        if (arst_n_i && out_valid_o && out_ready_i) begin
            wid = out_warp_id_o;
            check_equal("active flag of out_warp_id_o", exp_active[wid], 1'b1);
            r = ref_decode(prog[exp_pc[wid]], exp_pc[wid]);
            check_equal("out_pc_o", out_pc_o, exp_pc[wid]);
            check_equal("out_act_mask_o", out_act_mask_o, exp_mask[wid]);
            check_equal("out_opcode_o", out_opcode_o, r.opcode);
            check_equal("out_rd_o", out_rd_o, r.rd);
            check_equal("out_rs1_o", out_rs1_o, r.rs1);
            check_equal("out_rs2_o", out_rs2_o, r.rs2);
            check_equal("out_func_o", out_func_o, r.func);
            check_equal("out_illegal_o", out_illegal_o, r.illegal);
            seen_insts++;
            if (r.is_exit) begin
                exp_active[wid] = 1'b0;
                retires[wid]++;
                exit_chk = 1'b1;
                exit_wid = wid;
            end else begin
                exp_pc[wid] = r.next_pc;
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run hung after %0d instructions", seen_insts);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule : tb_gpu_front

`default_nettype wire
